//--- source/mshr_cfg.svh
`ifndef MSHR_CFG_SVH
`define MSHR_CFG_SVH

// number of outstanding misses held in the queue
`define MSHR_DEPTH 8

// cache-line address width
`define MSHR_ADDR_WIDTH 32

// one full line of data
`define MSHR_DATA_WIDTH 64

// memory transaction tag, zero means no transaction
`define MSHR_TAG_WIDTH 4

`endif

//--- source/mshr_pkg.sv
`include "mshr_cfg.svh"

package mshr_pkg;

  typedef logic [`MSHR_ADDR_WIDTH-1:0] line_addr_t;
  typedef logic [`MSHR_DATA_WIDTH-1:0] line_data_t;
  typedef logic [`MSHR_TAG_WIDTH-1:0] mem_tag_t;
  // wraps around the queue on its own
  typedef logic [$clog2(`MSHR_DEPTH)-1:0] mshr_idx_t;

  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_command_t;

  typedef enum logic [1:0] {
    waiting     = 2'd0,
    in_progress = 2'd1,
    done        = 2'd2
  } entry_state_t;

  typedef struct packed {
    line_addr_t   addr;
    line_data_t   data;
    bus_command_t command;
  } miss_req_t;

  typedef struct packed {
    bus_command_t command;
    line_addr_t   addr;
    line_data_t   data;
  } mem_req_t;

  typedef struct packed {
    mem_tag_t   accept_tag;
    mem_tag_t   done_tag;
    line_data_t done_data;
  } mem_resp_t;

  typedef struct packed {
    line_addr_t addr;
    line_data_t data;
  } fill_t;

  typedef struct packed {
    logic       valid;
    logic       is_store;
    line_addr_t addr;
    line_data_t data;
  } lookup_req_t;

  typedef struct packed {
    logic       hit;
    logic       data_valid;
    line_data_t data;
  } lookup_resp_t;

endpackage

//--- source/mshr_tag_match.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_tag_match
  import mshr_pkg::*;
(
  input  mem_tag_t                             done_tag,
  input  mem_tag_t [`MSHR_DEPTH-1:0]           entry_tag,
  input  entry_state_t [`MSHR_DEPTH-1:0]       entry_state,
  input  logic [`MSHR_DEPTH-1:0]               entry_valid,
  output logic                                 tag_hit,
  output mshr_idx_t                            tag_hit_idx
);

  // memory keeps live tags unique, so at most one entry matches
  always_comb begin
    tag_hit     = 1'b0;
    tag_hit_idx = '0;
    if (done_tag != '0) begin
      for (int i = 0; i < `MSHR_DEPTH; i++) begin
        if (entry_valid[i] && entry_state[i] == in_progress && entry_tag[i] == done_tag) begin
          tag_hit     = 1'b1;
          tag_hit_idx = mshr_idx_t'(i);
        end
      end
    end
  end

endmodule

//--- source/mshr_lookup.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_lookup
  import mshr_pkg::*;
(
  input  lookup_req_t                          lookup,
  input  mshr_idx_t                            tail,
  input  logic [`MSHR_DEPTH-1:0]               entry_valid,
  input  entry_state_t [`MSHR_DEPTH-1:0]       entry_state,
  input  line_addr_t [`MSHR_DEPTH-1:0]         entry_addr,
  input  line_data_t [`MSHR_DEPTH-1:0]         entry_data,
  input  bus_command_t [`MSHR_DEPTH-1:0]       entry_command,
  output lookup_resp_t                         lookup_result,
  output logic                                 merge_en,
  output mshr_idx_t                            merge_idx
);

  logic      found;
  mshr_idx_t sel_idx;
  logic      sel_store;
  logic      sel_waiting;
  logic      sel_load_done;
  logic      store_hit;

  // walk from the tail round to the youngest, last match wins
  always_comb begin
    mshr_idx_t idx;
    found   = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < `MSHR_DEPTH; i++) begin
      idx = tail + mshr_idx_t'(i);
      if (entry_valid[idx] && entry_addr[idx] == lookup.addr) begin
        found   = 1'b1;
        sel_idx = idx;
      end
    end
  end

  assign sel_store     = entry_command[sel_idx] == bus_store;
  assign sel_waiting   = entry_state[sel_idx] == waiting;
  assign sel_load_done = entry_command[sel_idx] == bus_load && entry_state[sel_idx] == done;

  // only a store not yet sent to memory can absorb new data
  assign store_hit = lookup.valid && lookup.is_store && found && sel_store && sel_waiting;

  always_comb begin
    lookup_result.data = entry_data[sel_idx];
    if (lookup.is_store) begin
      lookup_result.hit        = store_hit;
      lookup_result.data_valid = 1'b0;
    end else begin
      lookup_result.hit        = lookup.valid && found;
      lookup_result.data_valid = lookup.valid && found && (sel_store || sel_load_done);
    end
  end

  assign merge_en  = store_hit;
  assign merge_idx = sel_idx;

endmodule

//--- source/mshr_entry_file.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_entry_file
  import mshr_pkg::*;
(
  input  logic                                 clock,
  input  logic                                 alloc_en,
  input  mshr_idx_t                            alloc_idx,
  input  miss_req_t                            miss,
  input  logic                                 issue_en,
  input  mshr_idx_t                            issue_idx,
  input  mem_tag_t                             accept_tag,
  input  logic                                 tag_hit,
  input  mshr_idx_t                            tag_hit_idx,
  input  line_data_t                           done_data,
  input  logic                                 merge_en,
  input  mshr_idx_t                            merge_idx,
  input  line_data_t                           merge_data,
  output line_addr_t [`MSHR_DEPTH-1:0]         entry_addr,
  output line_data_t [`MSHR_DEPTH-1:0]         entry_data,
  output bus_command_t [`MSHR_DEPTH-1:0]       entry_command,
  output mem_tag_t [`MSHR_DEPTH-1:0]           entry_tag
);

  // address and command only change at allocation
  always_ff @(posedge clock) begin
    if (alloc_en) begin
      entry_addr[alloc_idx]    <= miss.addr;
      entry_command[alloc_idx] <= miss.command;
    end
  end

  // tag cleared on allocation, taken from memory on acceptance
  always_ff @(posedge clock) begin
    if (alloc_en) begin
      entry_tag[alloc_idx] <= '0;
    end
    if (issue_en) begin
      entry_tag[issue_idx] <= accept_tag;
    end
  end

  // line data has three writers, each on a different entry state
  always_ff @(posedge clock) begin
    if (alloc_en) begin
      entry_data[alloc_idx] <= miss.data;
    end
    if (tag_hit) begin
      entry_data[tag_hit_idx] <= done_data;
    end
    if (merge_en) begin
      entry_data[merge_idx] <= merge_data;
    end
  end

endmodule

//--- source/mshr_control.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_control
  import mshr_pkg::*;
(
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 miss_valid,
  output logic                                 miss_ready,
  input  mem_resp_t                            mem_resp,
  input  logic                                 fill_ready,
  output logic                                 fill_valid,
  output logic                                 empty,
  input  bus_command_t [`MSHR_DEPTH-1:0]       entry_command,
  input  logic                                 tag_hit,
  input  mshr_idx_t                            tag_hit_idx,
  input  logic                                 merge_en,
  input  mshr_idx_t                            merge_idx,
  output logic [`MSHR_DEPTH-1:0]               entry_valid,
  output entry_state_t [`MSHR_DEPTH-1:0]       entry_state,
  output logic                                 alloc_en,
  output mshr_idx_t                            alloc_idx,
  output logic                                 issue_en,
  output mshr_idx_t                            issue_idx,
  output bus_command_t                         mem_command,
  output mshr_idx_t                            fill_idx
);

  localparam logic [$clog2(`MSHR_DEPTH+1)-1:0] full_count = `MSHR_DEPTH;

  mshr_idx_t                        tail;
  mshr_idx_t                        head;
  mshr_idx_t                        retire;
  logic [$clog2(`MSHR_DEPTH+1)-1:0] count;
  logic                             head_pending;
  logic                             head_merge;
  logic                             retire_done;
  logic                             retire_en;

  assign miss_ready = count < full_count;
  assign empty      = count == '0;

  assign alloc_en  = miss_valid & miss_ready;
  assign alloc_idx = tail;

  assign head_pending = entry_valid[head] && entry_state[head] == waiting;
  // a store being merged this cycle would go out with stale data, hold it back
  assign head_merge   = merge_en && merge_idx == head;
  assign mem_command  = (head_pending && !head_merge) ? entry_command[head] : bus_none;
  assign issue_en     = mem_command != bus_none && mem_resp.accept_tag != '0;
  assign issue_idx    = head;

  assign fill_idx    = retire;
  assign retire_done = entry_valid[retire] && entry_state[retire] == done;
  assign fill_valid  = retire_done && entry_command[retire] == bus_load;
  // stores leave without a fill
  assign retire_en   = (fill_valid && fill_ready) ||
                       (retire_done && entry_command[retire] == bus_store);

  always_ff @(posedge clock) begin
    if (reset) begin
      tail   <= '0;
      head   <= '0;
      retire <= '0;
      count  <= '0;
    end else begin
      if (alloc_en) begin
        tail <= tail + 1'b1;
      end
      if (issue_en) begin
        head <= head + 1'b1;
      end
      if (retire_en) begin
        retire <= retire + 1'b1;
      end
      case ({alloc_en, retire_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // per-entry valid and state
  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
      for (int i = 0; i < `MSHR_DEPTH; i++) begin
        entry_state[i] <= waiting;
      end
    end else begin
      for (int i = 0; i < `MSHR_DEPTH; i++) begin
        if (retire_en && retire == mshr_idx_t'(i)) begin
          entry_valid[i] <= 1'b0;
        end
        if (alloc_en && tail == mshr_idx_t'(i)) begin
          entry_valid[i] <= 1'b1;
          entry_state[i] <= waiting;
        end
        if (issue_en && head == mshr_idx_t'(i)) begin
          // accepted stores need nothing back from memory
          entry_state[i] <= (entry_command[i] == bus_store) ? done : in_progress;
        end
        if (tag_hit && tag_hit_idx == mshr_idx_t'(i)) begin
          entry_state[i] <= done;
        end
      end
    end
  end

endmodule

//--- source/mshr_top.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_top
  import mshr_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         miss_valid,
  input  miss_req_t    miss,
  output logic         miss_ready,
  output mem_req_t     mem_req,
  input  mem_resp_t    mem_resp,
  output logic         fill_valid,
  output fill_t        fill,
  input  logic         fill_ready,
  input  lookup_req_t  lookup,
  output lookup_resp_t lookup_result,
  output logic         empty
);

  logic [`MSHR_DEPTH-1:0]         entry_valid;
  entry_state_t [`MSHR_DEPTH-1:0] entry_state;
  line_addr_t [`MSHR_DEPTH-1:0]   entry_addr;
  line_data_t [`MSHR_DEPTH-1:0]   entry_data;
  bus_command_t [`MSHR_DEPTH-1:0] entry_command;
  mem_tag_t [`MSHR_DEPTH-1:0]     entry_tag;
  logic                           alloc_en;
  mshr_idx_t                      alloc_idx;
  logic                           issue_en;
  mshr_idx_t                      issue_idx;
  bus_command_t                   mem_command;
  mshr_idx_t                      fill_idx;
  logic                           tag_hit;
  mshr_idx_t                      tag_hit_idx;
  logic                           merge_en;
  mshr_idx_t                      merge_idx;

  // head entry goes to memory, retire entry goes back to the cache
  assign mem_req.command = mem_command;
  assign mem_req.addr    = entry_addr[issue_idx];
  assign mem_req.data    = entry_data[issue_idx];
  assign fill.addr       = entry_addr[fill_idx];
  assign fill.data       = entry_data[fill_idx];

  mshr_control i_control (
    .clock, .reset, .miss_valid, .miss_ready, .mem_resp, .fill_ready, .fill_valid, .empty,
    .entry_command, .tag_hit, .tag_hit_idx, .merge_en, .merge_idx, .entry_valid,
    .entry_state, .alloc_en, .alloc_idx, .issue_en, .issue_idx, .mem_command, .fill_idx
  );

  mshr_entry_file i_entry_file (
    .clock, .alloc_en, .alloc_idx, .miss, .issue_en, .issue_idx,
    .accept_tag(mem_resp.accept_tag), .tag_hit, .tag_hit_idx,
    .done_data(mem_resp.done_data), .merge_en, .merge_idx, .merge_data(lookup.data),
    .entry_addr, .entry_data, .entry_command, .entry_tag
  );

  mshr_lookup i_lookup (
    .lookup, .tail(alloc_idx), .entry_valid, .entry_state, .entry_addr, .entry_data,
    .entry_command, .lookup_result, .merge_en, .merge_idx
  );

  mshr_tag_match i_tag_match (
    .done_tag(mem_resp.done_tag), .entry_tag, .entry_state, .entry_valid,
    .tag_hit, .tag_hit_idx
  );

endmodule

//--- verif/mshr_props.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_props
  import mshr_pkg::*;
(
  input logic                   clock,
  input logic                   reset,
  input logic [`MSHR_DEPTH-1:0] entry_valid,
  input logic                   miss_ready,
  input logic                   fill_valid,
  input logic                   fill_ready,
  input mshr_idx_t              fill_idx,
  input bus_command_t           mem_command
);

  // no room means no new miss
  full_blocks_miss: assert property (@(posedge clock) disable iff (reset)
    &entry_valid |-> !miss_ready)
    else $error("miss_ready high while the queue is full");

  // a stalled fill keeps pointing at the same entry
  fill_held: assert property (@(posedge clock) disable iff (reset)
    fill_valid && !fill_ready |=> fill_valid && $stable(fill_idx))
    else $error("fill changed while the cache was not ready");

  idle_after_reset: assert property (@(posedge clock)
    reset |=> mem_command == bus_none)
    else $error("memory request issued right after reset");

endmodule

//--- verif/mshr_tb.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_tb
  import mshr_pkg::*;
();

  localparam int depth = `MSHR_DEPTH;
  localparam int n_trans = 300;
  localparam line_data_t mem_key = 64'h5a5a_c3c3_0f0f_9696;

  logic         clock = 1'b0;
  logic         reset;
  logic         miss_valid;
  miss_req_t    miss;
  logic         miss_ready;
  mem_req_t     mem_req;
  mem_resp_t    mem_resp;
  logic         fill_valid;
  fill_t        fill;
  logic         fill_ready;
  lookup_req_t  lookup;
  lookup_resp_t lookup_result;
  logic         empty;

  // reference queue
  logic         m_valid [depth];
  entry_state_t m_state [depth];
  line_addr_t   m_addr [depth];
  line_data_t   m_data [depth];
  bus_command_t m_cmd [depth];
  mem_tag_t     m_tag [depth];
  int           m_seq [depth];
  int           tail, head, retire, count, seq_next, allocated, phase;
  integer       seed;

  // what the coming edge does
  logic         do_alloc, do_issue, do_done, do_merge, do_retire;
  int           done_idx, sel;
  logic         exp_hit, exp_dv;
  bus_command_t exp_cmd;

  mshr_top i_mshr_top (
    .clock, .reset, .miss_valid, .miss, .miss_ready, .mem_req, .mem_resp,
    .fill_valid, .fill, .fill_ready, .lookup, .lookup_result, .empty
  );

  bind mshr_control mshr_props i_props (
    .clock, .reset, .entry_valid, .miss_ready, .fill_valid, .fill_ready, .fill_idx,
    .mem_command
  );

  always #20 clock = ~clock;

  task automatic compare_value(string name, logic [127:0] expected, logic [127:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected %h got %h", name, expected, actual);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // memory hands out the lowest tag not held by a load in flight
  function automatic mem_tag_t lowest_free_tag();
    mem_tag_t t;
    logic     used;
    t = '0;
    for (int k = 15; k > 0; k--) begin
      used = 1'b0;
      for (int i = 0; i < depth; i++) begin
        if (m_valid[i] && m_state[i] == in_progress && m_tag[i] == mem_tag_t'(k)) used = 1'b1;
      end
      if (!used) t = mem_tag_t'(k);
    end
    return t;
  endfunction

  task automatic apply_edge();
    if (do_issue) begin
      m_tag[head] = mem_resp.accept_tag;
      m_state[head] = (m_cmd[head] == bus_store) ? done : in_progress;
      head = (head + 1) % depth;
    end
    if (do_done) begin
      m_state[done_idx] = done;
      m_data[done_idx] = mem_resp.done_data;
    end
    if (do_merge) m_data[sel] = lookup.data;
    if (do_retire) begin
      m_valid[retire] = 1'b0;
      retire = (retire + 1) % depth;
      count--;
    end
    if (do_alloc) begin
      m_valid[tail] = 1'b1;
      m_state[tail] = waiting;
      m_addr[tail] = miss.addr;
      m_data[tail] = miss.data;
      m_cmd[tail] = miss.command;
      m_tag[tail] = '0;
      m_seq[tail] = seq_next++;
      tail = (tail + 1) % depth;
      count++;
      allocated++;
    end
  endtask

  // phase 0 random traffic, 1 fill up with fills stalled, 2 drain, 3 idle
  task automatic drive_inputs();
    logic [31:0] r;
    r = $random(seed);
    miss_valid = (phase == 1) || (phase == 0 && r[0]);
    miss.addr = {29'h0000_0200, r[4:2]};
    miss.command = r[5] ? bus_store : bus_load;
    miss.data = {$random(seed), $random(seed)};
    fill_ready = (phase == 2) || (phase == 0 && r[6]);
    lookup.valid = phase == 0 && r[7];
    lookup.is_store = r[8];
    lookup.addr = {29'h0000_0200, r[11:9]};
    lookup.data = {$random(seed), $random(seed)};
  endtask

  task automatic evaluate();
    logic [31:0] r;
    logic        found;
    int          k;
    found = 1'b0;
    sel = 0;
    // youngest matching entry wins
    for (int i = 0; i < depth; i++) begin
      if (m_valid[i] && m_addr[i] == lookup.addr && (!found || m_seq[i] > m_seq[sel])) begin
        found = 1'b1;
        sel = i;
      end
    end
    do_merge = lookup.valid && lookup.is_store && found && m_cmd[sel] == bus_store &&
               m_state[sel] == waiting;
    exp_hit = lookup.valid && found && (!lookup.is_store || do_merge);
    exp_dv = lookup.valid && !lookup.is_store && found &&
             (m_cmd[sel] == bus_store || m_state[sel] == done);
    // head store sits out the cycle it takes merged data
    exp_cmd = (m_valid[head] && m_state[head] == waiting && !(do_merge && sel == head)) ?
              m_cmd[head] : bus_none;
    do_alloc = miss_valid && count < depth;
    do_retire = m_valid[retire] && m_state[retire] == done &&
                (m_cmd[retire] == bus_store || fill_ready);
    r = $random(seed);
    do_issue = exp_cmd != bus_none && r[0];
    mem_resp.accept_tag = do_issue ? lowest_free_tag() : '0;
    do_done = 1'b0;
    // completions picked from a random starting entry
    for (int i = 0; i < depth; i++) begin
      k = (int'(r[3:1]) + i) % depth;
      if (r[4] && !do_done && m_valid[k] && m_state[k] == in_progress) begin
        do_done = 1'b1;
        done_idx = k;
      end
    end
    mem_resp.done_tag = do_done ? m_tag[done_idx] : '0;
    mem_resp.done_data = do_done ? ({m_addr[done_idx], m_addr[done_idx]} ^ mem_key) : '0;
  endtask

  task automatic check_outputs();
    logic exp_fill;
    exp_fill = m_valid[retire] && m_state[retire] == done && m_cmd[retire] == bus_load;
    compare_value("miss_ready", count < depth, miss_ready);
    compare_value("empty", count == 0, empty);
    compare_value("mem_req.command", exp_cmd, mem_req.command);
    if (exp_cmd != bus_none) begin
      compare_value("mem_req.addr", m_addr[head], mem_req.addr);
      compare_value("mem_req.data", m_data[head], mem_req.data);
    end
    compare_value("fill_valid", exp_fill, fill_valid);
    if (exp_fill) begin
      compare_value("fill.addr", m_addr[retire], fill.addr);
      compare_value("fill.data", {m_addr[retire], m_addr[retire]} ^ mem_key, fill.data);
    end
    compare_value("lookup_result.hit", exp_hit, lookup_result.hit);
    compare_value("lookup_result.data_valid", exp_dv, lookup_result.data_valid);
    if (exp_dv) compare_value("lookup_result.data", m_data[sel], lookup_result.data);
  endtask

  initial begin
    seed = 45;
    reset = 1'b1;
    miss_valid = 1'b0;
    miss = '0;
    mem_resp = '0;
    fill_ready = 1'b0;
    lookup = '0;
    for (int i = 0; i < depth; i++) m_valid[i] = 1'b0;
    {tail, head, retire, count, seq_next, allocated, phase} = '0;
    {do_alloc, do_issue, do_done, do_merge, do_retire, exp_hit, exp_dv} = '0;
    sel = 0;
    done_idx = 0;
    exp_cmd = bus_none;
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;
    // idle queue right after reset
    @(negedge clock);
    check_outputs();
    while (phase != 3) begin
      @(posedge clock);
      #1;
      apply_edge();
      if (phase == 0 && allocated >= n_trans) phase = 1;
      else if (phase == 1 && count == depth) phase = 2;
      else if (phase == 2 && count == 0) phase = 3;
      drive_inputs();
      evaluate();
      @(negedge clock);
      check_outputs();
    end
    $display("All tests passed!");
    $finish;
  end

  // each transaction gets a generous cycle budget
  initial begin
    #(n_trans * 200 * 40);
    $display("timeout: the run did not finish in time");
    $display("Test failures found");
    $fatal(1);
  end

endmodule

//--- mshr_top.f
+incdir+source
source/mshr_pkg.sv
source/mshr_tag_match.sv
source/mshr_lookup.sv
source/mshr_entry_file.sv
source/mshr_control.sv
source/mshr_top.sv
verif/mshr_props.sv
verif/mshr_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mshr_tb
FILELIST = mshr_top.f
LOG      = sim.log
SIM      = obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(SIM) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
